/* hw/card_cam_pkg.sv */
package card_cam_pkg;

  // 1024x768 @ 60 Hz, 65 MHz pixel clock
  localparam int H_ACTIVE = 1024;
  localparam int H_FP     = 24;
  localparam int H_SYNC   = 136;
  localparam int H_TOTAL  = 1344;

  localparam int V_ACTIVE = 768;
  localparam int V_FP     = 3;
  localparam int V_SYNC   = 6;
  localparam int V_TOTAL  = 806;

  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // counters to registered vga pins
  localparam int VIDEO_LATENCY = 5;

  localparam logic [1:0] VIEW_CAMERA       = 2'd0;
  localparam logic [1:0] VIEW_MASK         = 2'd1;
  localparam logic [1:0] VIEW_CAMERA_CROSS = 2'd2;
  localparam logic [1:0] VIEW_MASK_CROSS   = 2'd3;

  localparam logic [11:0] CROSS_COLOR    = 12'h0F0;
  localparam logic [11:0] MASK_ON_COLOR  = 12'hFFF;
  localparam logic [11:0] MASK_OFF_COLOR = 12'h000;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] hi; // first byte off the camera
    logic [7:0] lo;
  } byte_pair_t;

  typedef union packed {
    rgb565_t    rgb;
    byte_pair_t bytes;
  } pixel565_t;

endpackage

/* hw/cam_capture.sv */
module cam_capture #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240,
  localparam int ADDR_W = $clog2(IMG_W * IMG_H)
) (
  input  logic                     clk_65mhz,
  input  logic                     sys_rst,
  input  logic                     cam_pclk,
  input  logic                     cam_href,
  input  logic                     cam_vsync,
  input  logic [7:0]               cam_data,
  output logic                     wr_en,
  output logic [ADDR_W-1:0]        wr_addr,
  output card_cam_pkg::pixel565_t  wr_pixel,
  output logic                     frame_done
);

  logic [1:0] pclk_sync;
  logic [1:0] href_sync;
  logic [1:0] vsync_sync;
  logic [7:0] data_meta;
  logic [7:0] data_sync;
  logic       pclk_prev;
  logic       vsync_prev;
  logic       pclk_rise;
  logic       byte_phase; // low while waiting for the high byte
  logic [7:0] hi_byte;

  // two flops per camera line, data delayed the same as pclk
  always_ff @(posedge clk_65mhz) begin
    pclk_sync  <= {pclk_sync[0], cam_pclk};
    href_sync  <= {href_sync[0], cam_href};
    vsync_sync <= {vsync_sync[0], cam_vsync};
    data_meta  <= cam_data;
    data_sync  <= data_meta;
  end

  assign pclk_rise = pclk_sync[1] & ~pclk_prev;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pclk_prev  <= 1'b0;
      vsync_prev <= 1'b0;
      byte_phase <= 1'b0;
      wr_en      <= 1'b0;
      wr_addr    <= '0;
      frame_done <= 1'b0;
    end else begin
      pclk_prev  <= pclk_sync[1];
      vsync_prev <= vsync_sync[1];
      frame_done <= vsync_sync[1] & ~vsync_prev;
      wr_en      <= 1'b0;
      if (vsync_sync[1]) begin
        // between frames, rewind to pixel 0
        byte_phase <= 1'b0;
        wr_addr    <= '0;
      end else begin
        if (wr_en) wr_addr <= wr_addr + 1'b1; // advance after each write
        if (pclk_rise && href_sync[1]) begin
          byte_phase <= ~byte_phase;
          wr_en      <= byte_phase; // second byte completes the pixel
        end
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (pclk_rise && href_sync[1]) begin
      if (!byte_phase) begin
        hi_byte <= data_sync;
      end else begin
        wr_pixel.bytes.hi <= hi_byte;
        wr_pixel.bytes.lo <= data_sync;
      end
    end
  end

endmodule

/* hw/frame_buffer.sv */
module frame_buffer #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240,
  localparam int DEPTH  = IMG_W * IMG_H,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic                     clk_65mhz,
  input  logic                     wr_en,
  input  logic [ADDR_W-1:0]        wr_addr,
  input  card_cam_pkg::pixel565_t  wr_pixel,
  input  logic [ADDR_W-1:0]        rd_addr,
  output card_cam_pkg::pixel565_t  rd_pixel
);

  import card_cam_pkg::*;

  pixel565_t         mem [DEPTH];
  logic [ADDR_W-1:0] rd_addr_q;

  always_ff @(posedge clk_65mhz) begin
    if (wr_en && (wr_addr < ADDR_W'(DEPTH))) begin // drop writes past the last line
      mem[wr_addr] <= wr_pixel;
    end
  end

  // address reg then output reg, two cycles like a bram with doutb reg
  always_ff @(posedge clk_65mhz) begin
    rd_addr_q <= rd_addr;
    rd_pixel  <= mem[rd_addr_q];
  end

endmodule

/* hw/vga_timing.sv */
module vga_timing (
  input  logic                                clk_65mhz,
  input  logic                                sys_rst,
  output logic [card_cam_pkg::HCOUNT_W-1:0]  hcount,
  output logic [card_cam_pkg::VCOUNT_W-1:0]  vcount,
  output logic                                hsync,
  output logic                                vsync,
  output logic                                blank
);

  import card_cam_pkg::*;

  localparam int HS_START = H_ACTIVE + H_FP;
  localparam int VS_START = V_ACTIVE + V_FP;

  logic h_last;
  logic v_last;

  assign h_last = (hcount == HCOUNT_W'(H_TOTAL - 1));
  assign v_last = (vcount == VCOUNT_W'(V_TOTAL - 1));

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      hcount <= h_last ? '0 : hcount + 1'b1;
      if (h_last) begin
        vcount <= v_last ? '0 : vcount + 1'b1; // next line at end of row
      end
    end
  end

  // decoded straight from the counters, same cycle
  always_comb begin
    hsync = (hcount >= HCOUNT_W'(HS_START)) && (hcount < HCOUNT_W'(HS_START + H_SYNC));
    vsync = (vcount >= VCOUNT_W'(VS_START)) && (vcount < VCOUNT_W'(VS_START + V_SYNC));
    blank = (hcount >= HCOUNT_W'(H_ACTIVE)) || (vcount >= VCOUNT_W'(V_ACTIVE));
  end

endmodule

/* hw/center_of_mass.sv */
module center_of_mass #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240
) (
  input  logic                                clk_65mhz,
  input  logic                                sys_rst,
  input  logic [card_cam_pkg::HCOUNT_W-1:0]  mask_x,
  input  logic [card_cam_pkg::VCOUNT_W-1:0]  mask_y,
  input  logic                                mask_hit,
  input  logic                                frame_start,
  output logic [card_cam_pkg::HCOUNT_W-1:0]  com_x,
  output logic [card_cam_pkg::VCOUNT_W-1:0]  com_y,
  output logic                                com_valid
);

  import card_cam_pkg::*;

  localparam int MAX_DIM = (IMG_W > IMG_H) ? IMG_W : IMG_H;
  localparam int CNT_W   = $clog2(IMG_W * IMG_H + 1);
  localparam int SUM_W   = $clog2(IMG_W * IMG_H * MAX_DIM + 1);
  localparam int Q_W     = HCOUNT_W; // wide enough for either mean
  localparam int DIV_W   = CNT_W + Q_W;
  localparam int STEP_W  = $clog2(Q_W);

  logic [SUM_W-1:0]  sum_x;
  logic [SUM_W-1:0]  sum_y;
  logic [CNT_W-1:0]  count;
  logic [DIV_W-1:0]  rem_x;
  logic [DIV_W-1:0]  rem_y;
  logic [DIV_W-1:0]  div_sh; // count aligned to the current quotient bit
  logic [Q_W-1:0]    q_x;
  logic [Q_W-1:0]    q_y;
  logic [Q_W-1:0]    q_x_next;
  logic [Q_W-1:0]    q_y_next;
  logic [DIV_W:0]    next_x;
  logic [DIV_W:0]    next_y;
  logic [STEP_W-1:0] step;
  logic              busy;

  // one restoring step, msb is the quotient bit
  function automatic logic [DIV_W:0] div_step(
    input logic [DIV_W-1:0] rem,
    input logic [DIV_W-1:0] divisor
  );
    if (rem >= divisor) return {1'b1, rem - divisor};
    return {1'b0, rem};
  endfunction

  assign next_x   = div_step(rem_x, div_sh);
  assign next_y   = div_step(rem_y, div_sh);
  assign q_x_next = {q_x[Q_W-2:0], next_x[DIV_W]};
  assign q_y_next = {q_y[Q_W-2:0], next_y[DIV_W]};

  // per-frame sums, the frame_start pixel opens the new frame
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (frame_start) begin
      sum_x <= mask_hit ? SUM_W'(mask_x) : '0;
      sum_y <= mask_hit ? SUM_W'(mask_y) : '0;
      count <= CNT_W'(mask_hit);
    end else if (mask_hit) begin
      sum_x <= sum_x + SUM_W'(mask_x);
      sum_y <= sum_y + SUM_W'(mask_y);
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      step      <= '0;
      com_valid <= 1'b0;
      com_x     <= '0;
      com_y     <= '0;
    end else begin
      com_valid <= 1'b0;
      if (frame_start && (count != '0)) begin
        busy <= 1'b1;
        step <= STEP_W'(Q_W - 1);
      end else if (busy) begin
        step <= step - 1'b1;
        if (step == '0) begin
          busy      <= 1'b0;
          com_valid <= 1'b1;
          com_x     <= q_x_next;
          com_y     <= q_y_next[VCOUNT_W-1:0];
        end
      end
    end
  end

  // divider datapath, both axes share the divisor
  always_ff @(posedge clk_65mhz) begin
    if (frame_start) begin
      rem_x  <= DIV_W'(sum_x);
      rem_y  <= DIV_W'(sum_y);
      div_sh <= DIV_W'(count) << (Q_W - 1);
      q_x    <= '0;
      q_y    <= '0;
    end else if (busy) begin
      rem_x  <= next_x[DIV_W-1:0];
      rem_y  <= next_y[DIV_W-1:0];
      q_x    <= q_x_next;
      q_y    <= q_y_next;
      div_sh <= div_sh >> 1;
    end
  end

endmodule

/* hw/video_out.sv */
module video_out #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240,
  localparam int ADDR_W = $clog2(IMG_W * IMG_H)
) (
  input  logic                                clk_65mhz,
  input  logic                                sys_rst,
  input  logic [card_cam_pkg::HCOUNT_W-1:0]  hcount,
  input  logic [card_cam_pkg::VCOUNT_W-1:0]  vcount,
  input  logic                                hsync,
  input  logic                                vsync,
  input  logic                                blank,
  input  card_cam_pkg::pixel565_t             rd_pixel,
  input  logic [1:0]                          view_sel,
  input  logic [6:0]                          dark_level,
  input  logic [card_cam_pkg::HCOUNT_W-1:0]  com_x,
  input  logic [card_cam_pkg::VCOUNT_W-1:0]  com_y,
  output logic [ADDR_W-1:0]                   rd_addr,
  output logic [card_cam_pkg::HCOUNT_W-1:0]  mask_x,
  output logic [card_cam_pkg::VCOUNT_W-1:0]  mask_y,
  output logic                                mask_hit,
  output logic                                frame_start,
  output logic [3:0]                          vga_r,
  output logic [3:0]                          vga_g,
  output logic [3:0]                          vga_b,
  output logic                                vga_hs,
  output logic                                vga_vs
);

  import card_cam_pkg::*;

  logic [HCOUNT_W-1:0]      h_pipe [4]; // stages 1..4
  logic [VCOUNT_W-1:0]      v_pipe [4];
  logic [2:0]               in_pipe;    // stages 1..3
  logic [3:0]               blank_pipe; // stages 1..4
  logic [VIDEO_LATENCY-1:0] hs_pipe;
  logic [VIDEO_LATENCY-1:0] vs_pipe;
  pixel565_t                pixel_q;
  logic                     in_image_q;
  logic                     in_now;
  logic [6:0]               level;
  logic [11:0]              cam_color;
  logic [11:0]              mask_color;
  logic [11:0]              mux_color;
  logic                     on_cross;

  assign mask_x = h_pipe[3];
  assign mask_y = v_pipe[3];
  assign vga_hs = ~hs_pipe[VIDEO_LATENCY-1]; // active low at the pins
  assign vga_vs = ~vs_pipe[VIDEO_LATENCY-1];

  always_comb begin
    in_now = (hcount < HCOUNT_W'(IMG_W)) && (vcount < VCOUNT_W'(IMG_H));
    // darkness sum with green halved to match the 5-bit channels
    level = 7'(rd_pixel.rgb.r) + 7'(rd_pixel.rgb.g[5:1]) + 7'(rd_pixel.rgb.b);
    cam_color = in_image_q ?
                {pixel_q.rgb.r[4:1], pixel_q.rgb.g[5:2], pixel_q.rgb.b[4:1]} : 12'h000;
    mask_color = mask_hit ? MASK_ON_COLOR : MASK_OFF_COLOR;
    on_cross = (mask_x == com_x) || (mask_y == com_y);
    case (view_sel)
      VIEW_CAMERA:       mux_color = cam_color;
      VIEW_MASK:         mux_color = mask_color;
      VIEW_CAMERA_CROSS: mux_color = on_cross ? CROSS_COLOR : cam_color;
      VIEW_MASK_CROSS:   mux_color = on_cross ? CROSS_COLOR : mask_color;
      default:           mux_color = cam_color;
    endcase
  end

  // address and position pipeline
  always_ff @(posedge clk_65mhz) begin
    rd_addr   <= in_now ? ADDR_W'(vcount * IMG_W + hcount) : '0;
    h_pipe[0] <= hcount;
    v_pipe[0] <= vcount;
    for (int i = 1; i < 4; i++) begin
      h_pipe[i] <= h_pipe[i-1];
      v_pipe[i] <= v_pipe[i-1];
    end
    pixel_q <= rd_pixel; // stage 4 where ram data lands
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      in_pipe     <= '0;
      blank_pipe  <= '1;
      hs_pipe     <= '0;
      vs_pipe     <= '0;
      in_image_q  <= 1'b0;
      mask_hit    <= 1'b0;
      frame_start <= 1'b0;
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
    end else begin
      in_pipe    <= {in_pipe[1:0], in_now};
      blank_pipe <= {blank_pipe[2:0], blank};
      hs_pipe    <= {hs_pipe[VIDEO_LATENCY-2:0], hsync};
      vs_pipe    <= {vs_pipe[VIDEO_LATENCY-2:0], vsync};

      // stage 4
      in_image_q  <= in_pipe[2];
      mask_hit    <= in_pipe[2] && (level < dark_level);
      frame_start <= (h_pipe[2] == '0) && (v_pipe[2] == '0);

      // stage 5 forces black during blanking
      vga_r <= blank_pipe[3] ? 4'h0 : mux_color[11:8];
      vga_g <= blank_pipe[3] ? 4'h0 : mux_color[7:4];
      vga_b <= blank_pipe[3] ? 4'h0 : mux_color[3:0];
    end
  end

endmodule

/* hw/card_cam_top.sv */
module card_cam_top #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240
) (
  input  logic                                clk_65mhz,
  input  logic                                sys_rst,
  input  logic                                cam_pclk,
  input  logic                                cam_href,
  input  logic                                cam_vsync,
  input  logic [7:0]                          cam_data,
  input  logic [1:0]                          view_sel,
  input  logic [6:0]                          dark_level,
  output logic [3:0]                          vga_r,
  output logic [3:0]                          vga_g,
  output logic [3:0]                          vga_b,
  output logic                                vga_hs,
  output logic                                vga_vs,
  output logic                                frame_done,
  output logic [card_cam_pkg::HCOUNT_W-1:0]  com_x,
  output logic [card_cam_pkg::VCOUNT_W-1:0]  com_y,
  output logic                                com_valid
);

  import card_cam_pkg::*;

  localparam int ADDR_W = $clog2(IMG_W * IMG_H);

  logic                wr_en;
  logic [ADDR_W-1:0]   wr_addr;
  pixel565_t           wr_pixel;
  logic [ADDR_W-1:0]   rd_addr;
  pixel565_t           rd_pixel;
  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic                hsync;
  logic                vsync;
  logic                blank;
  logic [HCOUNT_W-1:0] mask_x;
  logic [VCOUNT_W-1:0] mask_y;
  logic                mask_hit;
  logic                frame_start;

  cam_capture #(.IMG_W(IMG_W), .IMG_H(IMG_H)) capture (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .cam_pclk  (cam_pclk),
    .cam_href  (cam_href),
    .cam_vsync (cam_vsync),
    .cam_data  (cam_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_pixel  (wr_pixel),
    .frame_done(frame_done)
  );

  frame_buffer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) fbuf (
    .clk_65mhz(clk_65mhz),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_pixel (wr_pixel),
    .rd_addr  (rd_addr),
    .rd_pixel (rd_pixel)
  );

  vga_timing timing (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst),
    .hcount   (hcount),
    .vcount   (vcount),
    .hsync    (hsync),
    .vsync    (vsync),
    .blank    (blank)
  );

  video_out #(.IMG_W(IMG_W), .IMG_H(IMG_H)) video (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .hcount     (hcount),
    .vcount     (vcount),
    .hsync      (hsync),
    .vsync      (vsync),
    .blank      (blank),
    .rd_pixel   (rd_pixel),
    .view_sel   (view_sel),
    .dark_level (dark_level),
    .com_x      (com_x),
    .com_y      (com_y),
    .rd_addr    (rd_addr),
    .mask_x     (mask_x),
    .mask_y     (mask_y),
    .mask_hit   (mask_hit),
    .frame_start(frame_start),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b),
    .vga_hs     (vga_hs),
    .vga_vs     (vga_vs)
  );

  center_of_mass #(.IMG_W(IMG_W), .IMG_H(IMG_H)) com (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .mask_x     (mask_x),
    .mask_y     (mask_y),
    .mask_hit   (mask_hit),
    .frame_start(frame_start),
    .com_x      (com_x),
    .com_y      (com_y),
    .com_valid  (com_valid)
  );

endmodule

/* sim/clk_gen.sv */
module clk_gen #(
  parameter real HALF_PERIOD_NS = 50.0,
  parameter int  RST_CYCLES     = 8
) (
  output logic clk_65mhz,
  output logic sys_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_65mhz = 1'b0;
    forever #(HALF_PERIOD_NS) clk_65mhz = ~clk_65mhz;
  end

  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_65mhz);
    sys_rst <= 1'b0; // released on a rising edge
  end

endmodule

/* sim/card_cam_tb.sv */
module card_cam_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import card_cam_pkg::*;

  localparam int IMG_W      = 320;
  localparam int IMG_H      = 240;
  localparam int DARK_LEVEL = 40;
  localparam int RECT_X0    = 100; // dark rectangle with inclusive bounds
  localparam int RECT_X1    = 139;
  localparam int RECT_Y0    = 60;
  localparam int RECT_Y1    = 89;
  localparam int VS_TICKS   = 8;   // camera vsync high time in byte periods
  localparam int VS_GAP     = 4;
  localparam int LINE_GAP   = 4;
  localparam int HS_START   = H_ACTIVE + H_FP;
  localparam int VS_START   = V_ACTIVE + V_FP;
  localparam longint VGA_FRAME_CYC = H_TOTAL * V_TOTAL;
  localparam longint CAM_FRAME_CYC = 4 * (2 * VS_TICKS + VS_GAP + IMG_H * (2 * IMG_W + LINE_GAP));
  localparam longint WATCHDOG_NS   = 100 * (4 * VGA_FRAME_CYC + 2 * CAM_FRAME_CYC + 50_000);

  logic                clk_65mhz;
  logic                sys_rst;
  logic                cam_pclk;
  logic                cam_href;
  logic                cam_vsync;
  logic [7:0]          cam_data;
  logic [1:0]          view_sel;
  logic [6:0]          dark_level;
  logic [3:0]          vga_r;
  logic [3:0]          vga_g;
  logic [3:0]          vga_b;
  logic                vga_hs;
  logic                vga_vs;
  logic                frame_done;
  logic [HCOUNT_W-1:0] com_x;
  logic [VCOUNT_W-1:0] com_y;
  logic                com_valid;

  int   errors      = 0;
  int   checks      = 0;
  int   com_pulses  = 0;
  int   done_pulses = 0;
  int   cur_h       = 0; // reference position of the sampled vga outputs
  int   cur_v       = 0;
  int   cur_frame   = 0;
  int   frame_no    = 0;
  bit   in_vblank   = 1'b0;
  bit   synced      = 1'b0;
  bit   cam_done    = 1'b0;
  logic hs_q        = 1'b1;
  logic [1:0] view_q;
  int   bg_r;
  int   bg_g;
  int   bg_b;
  int   exp_cx;
  int   exp_cy;

  clk_gen clocks (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst)
  );

  card_cam_top uut (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .cam_pclk  (cam_pclk),
    .cam_href  (cam_href),
    .cam_vsync (cam_vsync),
    .cam_data  (cam_data),
    .view_sel  (view_sel),
    .dark_level(dark_level),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs),
    .frame_done(frame_done),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_valid (com_valid)
  );

  task automatic report_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  // zero inside the rectangle and light elsewhere
  function automatic logic [15:0] scene_pixel(input int x, input int y);
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
    if (x >= RECT_X0 && x <= RECT_X1 && y >= RECT_Y0 && y <= RECT_Y1) return 16'h0000;
    r = 5'(20 + (bg_r + x) % 12);
    g = 6'(40 + (bg_g + y) % 24);
    b = 5'(20 + (bg_b + x + y) % 12);
    return {r, g, b};
  endfunction

  // r + g/2 + b below the threshold
  function automatic bit is_dark(input logic [15:0] p);
    return (int'(p[15:11]) + int'(p[10:6]) + int'(p[4:0])) < DARK_LEVEL;
  endfunction

  // one byte per pclk period with pclk at clk/4
  task automatic cam_byte(input logic [7:0] d, input logic href, input logic vs);
    @(posedge clk_65mhz);
    cam_pclk  <= 1'b0;
    cam_data  <= d;
    cam_href  <= href;
    cam_vsync <= vs;
    @(posedge clk_65mhz);
    @(posedge clk_65mhz);
    cam_pclk <= 1'b1;
    @(posedge clk_65mhz);
  endtask

  task automatic play_frame();
    logic [15:0] p;
    repeat (VS_TICKS) cam_byte(8'h00, 1'b0, 1'b1);
    repeat (VS_GAP) cam_byte(8'h00, 1'b0, 1'b0);
    for (int y = 0; y < IMG_H; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        p = scene_pixel(x, y);
        cam_byte(p[15:8], 1'b1, 1'b0); // high byte first
        cam_byte(p[7:0], 1'b1, 1'b0);
      end
      repeat (LINE_GAP) cam_byte(8'h00, 1'b0, 1'b0);
    end
    repeat (VS_TICKS) cam_byte(8'h00, 1'b0, 1'b1); // closing vsync
  endtask

  task automatic wait_vblank(input int frame);
    do @(posedge clk_65mhz); while (!(frame_no == frame && in_vblank));
  endtask

  always @(posedge clk_65mhz) begin : output_check
    logic [15:0] pix;
    logic [11:0] cam_c;
    logic [11:0] mask_c;
    logic [11:0] want;
    logic [11:0] got;
    bit          in_img;
    bit          on_cross;
    if (sys_rst) begin
      synced = 1'b0;
      hs_q   = 1'b1;
      view_q = view_sel;
    end else begin
      if (synced) begin
        cur_h = (cur_h == H_TOTAL - 1) ? 0 : cur_h + 1;
        if (cur_h == 0) begin
          cur_v = (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
          if (cur_v == 0) cur_frame++;
        end
      end else if (hs_q && !vga_hs) begin
        synced    = 1'b1; // first hsync fall marks h 1048 of line 0
        cur_h     = HS_START;
        cur_v     = 0;
        cur_frame = 0;
      end
      hs_q = vga_hs;
      if (synced) begin
        checks++;
        assert (vga_hs == !(cur_h >= HS_START && cur_h < HS_START + H_SYNC))
          else report_mismatch($sformatf("vga_hs is %b at h=%0d", vga_hs, cur_h));
        assert (vga_vs == !(cur_v >= VS_START && cur_v < VS_START + V_SYNC))
          else report_mismatch($sformatf("vga_vs is %b at v=%0d", vga_vs, cur_v));
        got = {vga_r, vga_g, vga_b};
        if (cur_h >= H_ACTIVE || cur_v >= V_ACTIVE) begin
          assert (got === 12'h000)
            else report_mismatch($sformatf("color %h in blanking at (%0d,%0d)",
                                           got, cur_h, cur_v));
        end else if (cur_frame >= 1) begin
          in_img   = (cur_h < IMG_W) && (cur_v < IMG_H);
          pix      = in_img ? scene_pixel(cur_h, cur_v) : 16'h0000;
          cam_c    = in_img ? {pix[15:12], pix[10:7], pix[4:1]} : 12'h000;
          mask_c   = (in_img && is_dark(pix)) ? MASK_ON_COLOR : MASK_OFF_COLOR;
          on_cross = (cur_h == exp_cx) || (cur_v == exp_cy);
          case (view_q)
            VIEW_MASK:         want = mask_c;
            VIEW_CAMERA_CROSS: want = on_cross ? CROSS_COLOR : cam_c;
            VIEW_MASK_CROSS:   want = on_cross ? CROSS_COLOR : mask_c;
            default:           want = cam_c;
          endcase
          assert (got === want)
            else report_mismatch($sformatf("view %0d at (%0d,%0d): got %h, expected %h",
                                           view_q, cur_h, cur_v, got, want));
        end
        if (cur_frame == 1 && cur_h == 0 && cur_v == 0) begin
          assert (cam_done)
            else note_failure("camera frame was still being written when checking began");
        end
        if (com_valid && cur_frame >= 2) begin
          com_pulses++;
          assert (com_x == exp_cx && com_y == exp_cy)
            else report_mismatch($sformatf("centroid (%0d,%0d), expected (%0d,%0d)",
                                           com_x, com_y, exp_cx, exp_cy));
        end
      end
      if (frame_done) done_pulses++;
      view_q = view_sel; // the dut used this value for the next output
      frame_no  <= cur_frame;
      in_vblank <= synced && (cur_v >= VS_START + V_SYNC);
    end
  end

  initial begin : stimulus
    longint sx;
    longint sy;
    int     n;
    cam_pclk   <= 1'b0;
    cam_href   <= 1'b0;
    cam_vsync  <= 1'b0;
    cam_data   <= 8'h00;
    view_sel   <= VIEW_CAMERA;
    dark_level <= 7'(DARK_LEVEL);
    void'($urandom(58));
    bg_r = $urandom_range(11, 0);
    bg_g = $urandom_range(23, 0);
    bg_b = $urandom_range(11, 0);
    sx = 0;
    sy = 0;
    n  = 0;
    for (int y = 0; y < IMG_H; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        if (is_dark(scene_pixel(x, y))) begin
          sx += x;
          sy += y;
          n++;
        end
      end
    end
    exp_cx = int'(sx / n); // floor of the mean
    exp_cy = int'(sy / n);

    @(posedge clk_65mhz);
    while (sys_rst) @(posedge clk_65mhz);
    play_frame();
    cam_done <= 1'b1;

    // camera view in frame 1 then mask and the two cross views
    wait_vblank(1);
    view_sel <= VIEW_MASK;
    wait_vblank(2);
    view_sel <= VIEW_MASK_CROSS;
    wait_vblank(3);
    view_sel <= VIEW_CAMERA_CROSS;
    wait_vblank(4);

    assert (com_pulses > 0)
      else note_failure("com_valid never pulsed after the filled frame was shown");
    assert (done_pulses == 2)
      else report_mismatch($sformatf("expected 2 frame_done pulses, saw %0d", done_pulses));
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

/* sim.f */
hw/card_cam_pkg.sv
hw/cam_capture.sv
hw/frame_buffer.sv
hw/vga_timing.sv
hw/center_of_mass.sv
hw/video_out.sv
hw/card_cam_top.sv
sim/clk_gen.sv
sim/card_cam_tb.sv

/* Bender.yml */
package:
  name: card_cam

sources:
  - files:
      - hw/card_cam_pkg.sv
      - hw/cam_capture.sv
      - hw/frame_buffer.sv
      - hw/vga_timing.sv
      - hw/center_of_mass.sv
      - hw/video_out.sv
      - hw/card_cam_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/card_cam_tb.sv
